//--- Bender.yml
package:
  name: rs5_lsu

sources:
  - source/rs5_lsu_pkg.sv
  - source/mem_access.sv
  - source/data_ram.sv
  - source/retire.sv
  - source/regbank.sv
  - source/lsu_csr.sv
  - source/lsu_top.sv
  - target: test
    files:
      - tests/lsu_chk.sv
      - tests/lsu_tb.sv

//--- all.f
source/rs5_lsu_pkg.sv
source/mem_access.sv
source/data_ram.sv
source/retire.sv
source/regbank.sv
source/lsu_csr.sv
source/lsu_top.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

//--- source/data_ram.sv
/*
 * Data RAM.
 * Word-wide synchronous memory with byte-lane write strobes
 * and a one-cycle registered read.
 */

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [3:0]                   we_i,
    input  logic [$clog2(MEM_WORDS)-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);

    logic [31:0] mem [MEM_WORDS];        // Contents survive reset.

    // Byte lane writes.
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we_i[lane]) begin
                mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
            end
        end
    end

    // Read before write on the same word.
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

//--- source/lsu_csr.sv
/*
 * LSU control registers.
 * AXI4-Lite slave with the enable bit, the retired-request counter and
 * the misaligned-access counter with its sticky flag.
 */

module lsu_csr (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] s_awaddr_i,
    input  logic        s_awvalid_i,
    output logic        s_awready_o,
    input  logic [31:0] s_wdata_i,
    input  logic [3:0]  s_wstrb_i,
    input  logic        s_wvalid_i,
    output logic        s_wready_o,
    output logic [1:0]  s_bresp_o,
    output logic        s_bvalid_o,
    input  logic        s_bready_i,
    input  logic [31:0] s_araddr_i,
    input  logic        s_arvalid_i,
    output logic        s_arready_o,
    output logic [31:0] s_rdata_o,
    output logic [1:0]  s_rresp_o,
    output logic        s_rvalid_o,
    input  logic        s_rready_i,
    input  logic        retire_pulse_i,
    input  logic        misalign_pulse_i,
    output logic        enable_o
);

    logic        wr_ready_q;             // Shared AWREADY and WREADY.
    logic        wr_hs;
    logic        rd_hs;
    logic [31:0] wr_mask;
    logic        wr_ctrl;
    logic        wr_retired;
    logic        wr_misalign;
    logic        sticky_q;
    logic [31:0] retired_q;
    logic [31:0] misalign_q;

    assign s_awready_o = wr_ready_q;
    assign s_wready_o  = wr_ready_q;
    assign s_bresp_o   = rs5_lsu_pkg::AXI_RESP_OKAY;
    assign s_rresp_o   = rs5_lsu_pkg::AXI_RESP_OKAY;

    assign wr_hs = s_awvalid_i && s_wvalid_i && wr_ready_q;
    assign rd_hs = s_arvalid_i && s_arready_o;

    assign wr_mask = {{8{s_wstrb_i[3]}}, {8{s_wstrb_i[2]}}, {8{s_wstrb_i[1]}}, {8{s_wstrb_i[0]}}};

    // Address decode.
    assign wr_ctrl     = wr_hs && (s_awaddr_i == rs5_lsu_pkg::CSR_CTRL);
    assign wr_retired  = wr_hs && (s_awaddr_i == rs5_lsu_pkg::CSR_RETIRED);
    assign wr_misalign = wr_hs && (s_awaddr_i == rs5_lsu_pkg::CSR_MISALIGN);

    // Handshake control.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ready_q  <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else begin
            wr_ready_q  <= s_awvalid_i && s_wvalid_i && !wr_ready_q && !s_bvalid_o;  // One cycle.
            s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;
            if (wr_hs) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            if (rd_hs) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    // Read data sampled at the address handshake.
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (s_araddr_i)
                rs5_lsu_pkg::CSR_CTRL:     s_rdata_o <= {30'b0, sticky_q, enable_o};
                rs5_lsu_pkg::CSR_RETIRED:  s_rdata_o <= retired_q;
                rs5_lsu_pkg::CSR_MISALIGN: s_rdata_o <= misalign_q;
                default:                   s_rdata_o <= 32'h0000_0000;    // Unmapped.
            endcase
        end
    end

    // Enable, sticky flag and counters; bus writes win over pulses.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_o   <= 1'b1;
            sticky_q   <= 1'b0;
            retired_q  <= 32'h0000_0000;
            misalign_q <= 32'h0000_0000;
        end else begin
            if (wr_ctrl && wr_mask[rs5_lsu_pkg::CTRL_EN_BIT]) begin
                enable_o <= s_wdata_i[rs5_lsu_pkg::CTRL_EN_BIT];
            end
            if (misalign_pulse_i) begin
                sticky_q <= 1'b1;                // Set beats clear.
            end else if (wr_ctrl && wr_mask[rs5_lsu_pkg::CTRL_STICKY_BIT]
                         && s_wdata_i[rs5_lsu_pkg::CTRL_STICKY_BIT]) begin
                sticky_q <= 1'b0;
            end
            if (wr_retired) begin
                retired_q <= (retired_q & ~wr_mask) | (s_wdata_i & wr_mask);
            end else if (retire_pulse_i) begin
                retired_q <= retired_q + 32'd1;  // Wraps.
            end
            if (wr_misalign) begin
                misalign_q <= (misalign_q & ~wr_mask) | (s_wdata_i & wr_mask);
            end else if (misalign_pulse_i) begin
                misalign_q <= misalign_q + 32'd1;
            end
        end
    end

endmodule

//--- source/lsu_top.sv
/*
 * LSU top level.
 * Memory-access and write-back slice: request stage, data RAM, retire,
 * register bank and the AXI4-Lite control block.
 */

module lsu_top #(
    parameter rs5_lsu_pkg::rv32_e RV32      = rs5_lsu_pkg::RV32I,
    parameter int                 MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rs5_lsu_pkg::lsu_req_t req_i,
    input  logic [4:0]            rs_addr_i,
    output logic [31:0]           rs_data_o,
    input  logic [31:0]           s_awaddr_i,
    input  logic                  s_awvalid_i,
    output logic                  s_awready_o,
    input  logic [31:0]           s_wdata_i,
    input  logic [3:0]            s_wstrb_i,
    input  logic                  s_wvalid_i,
    output logic                  s_wready_o,
    output logic [1:0]            s_bresp_o,
    output logic                  s_bvalid_o,
    input  logic                  s_bready_i,
    input  logic [31:0]           s_araddr_i,
    input  logic                  s_arvalid_i,
    output logic                  s_arready_o,
    output logic [31:0]           s_rdata_o,
    output logic [1:0]            s_rresp_o,
    output logic                  s_rvalid_o,
    input  logic                  s_rready_i
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic                  enable;
    logic [3:0]            ram_we;
    logic [ADDR_W-1:0]     ram_addr;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_rdata;
    rs5_lsu_pkg::lsu_req_t stage;          // Request in the retire cycle.
    rs5_lsu_pkg::wb_t      wb;
    logic                  retire_pulse;
    logic                  misalign_pulse;

    mem_access #(.MEM_WORDS(MEM_WORDS)) u_mem_access (
        .clk(clk), .reset_i(reset_i), .req_i(req_i), .enable_i(enable),
        .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
        .stage_o(stage), .retire_pulse_o(retire_pulse), .misalign_pulse_o(misalign_pulse)
    );

    data_ram #(.MEM_WORDS(MEM_WORDS)) u_data_ram (
        .clk(clk), .we_i(ram_we), .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

    retire #(.RV32(RV32)) u_retire (
        .stage_i(stage), .mem_data_i(ram_rdata), .wb_o(wb)
    );

    regbank u_regbank (
        .clk(clk), .wb_i(wb), .rs_addr_i(rs_addr_i), .rs_data_o(rs_data_o)
    );

    lsu_csr u_lsu_csr (
        .clk(clk), .reset_i(reset_i),
        .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
        .s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
        .s_wready_o(s_wready_o), .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o),
        .s_bready_i(s_bready_i), .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i),
        .s_arready_o(s_arready_o), .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
        .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
        .retire_pulse_i(retire_pulse), .misalign_pulse_i(misalign_pulse), .enable_o(enable)
    );

endmodule

//--- source/mem_access.sv
/*
 * Memory access stage.
 * Checks alignment, builds store strobes and lane-replicated store data,
 * drives the data RAM and registers the request for retire.
 */

module mem_access #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         reset_i,
    input  rs5_lsu_pkg::lsu_req_t        req_i,
    input  logic                         enable_i,
    output logic [3:0]                   ram_we_o,
    output logic [$clog2(MEM_WORDS)-1:0] ram_addr_o,
    output logic [31:0]                  ram_wdata_o,
    output rs5_lsu_pkg::lsu_req_t        stage_o,
    output logic                         retire_pulse_o,
    output logic                         misalign_pulse_o
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic                   accept;
    logic                   misaligned;
    logic [3:0]             lane_mask;
    rs5_lsu_pkg::mem_word_u store_word;

    assign accept = req_i.valid && enable_i;     // No back-pressure.

    // Alignment rules per access size.
    always_comb begin
        case (req_i.op)
            rs5_lsu_pkg::LH,
            rs5_lsu_pkg::LHU,
            rs5_lsu_pkg::SH: misaligned = req_i.result[0];
            rs5_lsu_pkg::LW,
            rs5_lsu_pkg::SW: misaligned = |req_i.result[1:0];
            default:         misaligned = 1'b0;  // Bytes and non-memory ops.
        endcase
    end

    // Store data replicated into every lane; strobes pick the addressed lanes.
    always_comb begin
        store_word = req_i.store_data;           // Word store as is.
        lane_mask  = 4'b0000;
        case (req_i.op)
            rs5_lsu_pkg::SB: begin
                store_word.bytes = {4{req_i.store_data[7:0]}};
                lane_mask        = 4'b0001 << req_i.result[1:0];
            end
            rs5_lsu_pkg::SH: begin
                store_word.halves = {2{req_i.store_data[15:0]}};
                lane_mask         = req_i.result[1] ? 4'b1100 : 4'b0011;
            end
            rs5_lsu_pkg::SW: lane_mask = 4'b1111;
            default:         lane_mask = 4'b0000;
        endcase
    end

    assign retire_pulse_o   = accept && !misaligned;
    assign misalign_pulse_o = accept && misaligned;

    assign ram_we_o    = retire_pulse_o ? lane_mask : 4'b0000;   // Dropped accesses never write.
    assign ram_addr_o  = req_i.result[ADDR_W+1:2];               // Word index.
    assign ram_wdata_o = store_word;

    // Stage register towards retire; only valid is under reset.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_o.valid <= 1'b0;
        end else begin
            stage_o       <= req_i;
            stage_o.valid <= retire_pulse_o;     // Misaligned or disabled requests vanish.
        end
    end

endmodule

//--- source/regbank.sv
/*
 * Register bank.
 * 32 x 32 integer registers with one write port and one combinational
 * read port. Register 0 reads zero.
 */

module regbank (
    input  logic                  clk,
    input  rs5_lsu_pkg::wb_t      wb_i,
    input  logic [4:0]            rs_addr_i,
    output logic [31:0]           rs_data_o
);

    logic [31:0] regs [1:31];            // No storage for x0.

    // Write port.
    always_ff @(posedge clk) begin
        if (wb_i.en && (wb_i.rd != 5'd0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Read port with no write bypass.
    always_comb begin
        if (rs_addr_i == 5'd0) begin
            rs_data_o = 32'h0000_0000;
        end else begin
            rs_data_o = regs[rs_addr_i];
        end
    end

endmodule

//--- source/retire.sv
/*
 * Retire stage.
 * Extracts and extends load data, then picks the write-back value among
 * memory data, multiplier result and execute result.
 */

module retire #(
    parameter rs5_lsu_pkg::rv32_e RV32 = rs5_lsu_pkg::RV32I
) (
    input  rs5_lsu_pkg::lsu_req_t stage_i,
    input  logic [31:0]           mem_data_i,
    output rs5_lsu_pkg::wb_t      wb_o
);

    // Multiplier path exists in M and Zmmul.
    localparam bit HAS_MUL = (RV32 == rs5_lsu_pkg::RV32M) || (RV32 == rs5_lsu_pkg::RV32ZMMUL);

    rs5_lsu_pkg::mem_word_u mem_word;
    logic [7:0]             load_byte;
    logic [15:0]            load_half;
    logic [31:0]            load_data;

    assign mem_word  = mem_data_i;
    assign load_byte = mem_word.bytes[stage_i.result[1:0]];  // Lane from low address bits.
    assign load_half = mem_word.halves[stage_i.result[1]];

    // Sign or zero extension per load type.
    always_comb begin
        case (stage_i.op)
            rs5_lsu_pkg::LB:  load_data = {{24{load_byte[7]}}, load_byte};
            rs5_lsu_pkg::LBU: load_data = {24'b0, load_byte};
            rs5_lsu_pkg::LH:  load_data = {{16{load_half[15]}}, load_half};
            rs5_lsu_pkg::LHU: load_data = {16'b0, load_half};
            default:          load_data = mem_data_i;             // LW.
        endcase
    end

    // Write-back request.
    always_comb begin
        wb_o.rd = stage_i.rd;
        wb_o.en = stage_i.valid && (stage_i.rd != 5'd0);
        case (stage_i.op)
            rs5_lsu_pkg::LB,
            rs5_lsu_pkg::LBU,
            rs5_lsu_pkg::LH,
            rs5_lsu_pkg::LHU,
            rs5_lsu_pkg::LW: wb_o.data = load_data;
            rs5_lsu_pkg::MUL: wb_o.data = HAS_MUL ? stage_i.mul_result : stage_i.result;
            rs5_lsu_pkg::SB,
            rs5_lsu_pkg::SH,
            rs5_lsu_pkg::SW: begin
                wb_o.data = stage_i.result;
                wb_o.en   = 1'b0;                                 // Stores write no register.
            end
            default:         wb_o.data = stage_i.result;          // ALU.
        endcase
    end

endmodule

//--- source/rs5_lsu_pkg.sv
/*
 * RS5 LSU package.
 * Operation and ISA-variant encodings, the request and write-back records,
 * the memory word views and the register map of the memory-access slice.
 */

package rs5_lsu_pkg;

    // Operation code carried by each request.
    typedef enum logic [3:0] {
        ALU,                              // Execute result goes to rd.
        MUL,                              // Multiplier result goes to rd.
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } iType_e;

    // ISA variant of the core.
    typedef enum logic [1:0] {
        RV32I,
        RV32M,
        RV32ZMMUL
    } rv32_e;

    // Request from the execute stage.
    typedef struct packed {
        logic        valid;
        iType_e      op;
        logic [31:0] result;              // Also the byte address for loads and stores.
        logic [31:0] mul_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } lsu_req_t;

    // One memory word, seen as bytes or as halves.
    typedef union packed {
        logic [3:0][7:0]  bytes;          // Lane 0 is the lowest address.
        logic [1:0][15:0] halves;
    } mem_word_u;

    // Register bank write request.
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    // Register map.
    localparam logic [31:0] CSR_CTRL     = 32'h0000_0000;
    localparam logic [31:0] CSR_RETIRED  = 32'h0000_0004;
    localparam logic [31:0] CSR_MISALIGN = 32'h0000_0008;

    // CTRL fields.
    localparam int CTRL_EN_BIT     = 0;   // Request path enable.
    localparam int CTRL_STICKY_BIT = 1;   // Misaligned flag, write 1 to clear.

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

//--- tests/lsu_chk.sv
/*
 * LSU checker.
 * Keeps a shadow register file, a shadow data memory and counter models
 * from the request stream and compares them with the DUT.
 */

module lsu_chk #(
    parameter int MEM_WORDS = 256
) (
    input logic                  clk,
    input logic                  reset_i,
    input rs5_lsu_pkg::lsu_req_t req_i,
    input logic                  enable_i,
    input logic [4:0]            rs_addr_i,
    input logic [31:0]           rs_data_i,
    input logic [31:0]           retired_i,
    input logic [31:0]           misalign_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [31:0]      shadow_mem [MEM_WORDS];
    logic [31:0]      shadow_reg [32];
    logic [31:0]      known;                  // Registers holding a modeled value.
    rs5_lsu_pkg::wb_t pend_q;                 // Write-back due at the next edge.
    logic [31:0]      exp_retired;
    logic [31:0]      exp_misalign;
    logic             taken;
    logic             misaligned;
    logic             is_store;
    logic [31:0]      word;
    logic [31:0]      shifted;
    logic [31:0]      wb_val;
    logic [31:0]      exp_rs;
    logic             rs_known;
    int               fail_cnt;

    assign taken    = req_i.valid && enable_i;
    assign is_store = req_i.op inside {rs5_lsu_pkg::SB, rs5_lsu_pkg::SH, rs5_lsu_pkg::SW};
    assign word     = shadow_mem[req_i.result[ADDR_W+1:2]];
    assign shifted  = word >> (8 * req_i.result[1:0]);   // Addressed lane moved to bit 0.
    assign exp_rs   = (rs_addr_i == 5'd0) ? 32'h0 : shadow_reg[rs_addr_i];
    assign rs_known = (rs_addr_i == 5'd0) || known[rs_addr_i];

    // Halves need an even address, words a multiple of four.
    always_comb begin
        case (req_i.op)
            rs5_lsu_pkg::LH, rs5_lsu_pkg::LHU, rs5_lsu_pkg::SH: misaligned = req_i.result[0];
            rs5_lsu_pkg::LW, rs5_lsu_pkg::SW:                   misaligned = |req_i.result[1:0];
            default:                                            misaligned = 1'b0;
        endcase
    end

    // Value the request should leave in rd.
    always_comb begin
        case (req_i.op)
            rs5_lsu_pkg::LB:  wb_val = {{24{shifted[7]}}, shifted[7:0]};
            rs5_lsu_pkg::LBU: wb_val = {24'h0, shifted[7:0]};
            rs5_lsu_pkg::LH:  wb_val = {{16{shifted[15]}}, shifted[15:0]};
            rs5_lsu_pkg::LHU: wb_val = {16'h0, shifted[15:0]};
            rs5_lsu_pkg::LW:  wb_val = word;
            rs5_lsu_pkg::MUL: wb_val = req_i.mul_result;     // Core built as RV32M.
            default:          wb_val = req_i.result;
        endcase
    end

    // Reference pipeline, one edge for the access and one for the write-back.
    always @(posedge clk) begin
        if (reset_i) begin
            pend_q.en    <= 1'b0;
            known        <= 32'h0;
            exp_retired  <= 32'h0;
            exp_misalign <= 32'h0;
        end else begin
            pend_q.en   <= taken && !misaligned && !is_store && (req_i.rd != 5'd0);
            pend_q.rd   <= req_i.rd;
            pend_q.data <= wb_val;
            if (pend_q.en) begin
                shadow_reg[pend_q.rd] <= pend_q.data;
                known[pend_q.rd]      <= 1'b1;
            end
            if (taken && !misaligned) begin
                exp_retired <= exp_retired + 32'd1;
                case (req_i.op)
                    rs5_lsu_pkg::SB: shadow_mem[req_i.result[ADDR_W+1:2]]
                        [8*req_i.result[1:0] +: 8] <= req_i.store_data[7:0];
                    rs5_lsu_pkg::SH: shadow_mem[req_i.result[ADDR_W+1:2]]
                        [16*req_i.result[1] +: 16] <= req_i.store_data[15:0];
                    rs5_lsu_pkg::SW: shadow_mem[req_i.result[ADDR_W+1:2]] <= req_i.store_data;
                    default: ;
                endcase
            end
            if (taken && misaligned) exp_misalign <= exp_misalign + 32'd1;
        end
    end

    reg_match: assert property (@(posedge clk) disable iff (reset_i)
        rs_known |-> (rs_data_i == exp_rs))
        else begin
            $error("[ERROR] rs_data_o x%0d expected %h, got %h",
                   $sampled(rs_addr_i), $sampled(exp_rs), $sampled(rs_data_i));
            fail_cnt++;
        end

    retired_match: assert property (@(posedge clk) disable iff (reset_i)
        retired_i == exp_retired)
        else begin
            $error("[ERROR] retired_q expected %h, got %h", $sampled(exp_retired),
                   $sampled(retired_i));
            fail_cnt++;
        end

    misalign_match: assert property (@(posedge clk) disable iff (reset_i)
        misalign_i == exp_misalign)
        else begin
            $error("[ERROR] misalign_q expected %h, got %h", $sampled(exp_misalign),
                   $sampled(misalign_i));
            fail_cnt++;
        end

endmodule

bind lsu_top lsu_chk #(.MEM_WORDS(MEM_WORDS)) chk0 (
    .clk(clk), .reset_i(reset_i), .req_i(req_i), .enable_i(enable),
    .rs_addr_i(rs_addr_i), .rs_data_i(rs_data_o),
    .retired_i(u_lsu_csr.retired_q), .misalign_i(u_lsu_csr.misalign_q)
);

//--- tests/lsu_tb.sv
/*
 * LSU testbench.
 * Drives requests and AXI4-Lite accesses into the LSU slice, reads back
 * registers and control registers; the bound checker models the datapath.
 */

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD      = 100;
    localparam int TEST_CYCLES = 70 + 210 + 45 + 25 + 70;  // Per test, in test order.
    localparam int MARGIN      = 200;

    logic                  clk = 1'b0;
    logic                  reset_i;
    rs5_lsu_pkg::lsu_req_t req_i;
    logic [4:0]            rs_addr_i;
    logic [31:0]           rs_data_o;
    logic [31:0]           s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
    logic [3:0]            s_wstrb_i;
    logic [1:0]            s_bresp_o, s_rresp_o;
    logic                  s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
    logic                  s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
    int                    seed = 44918;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    accepted = 0;            // Aligned requests taken while enabled.

    lsu_top #(.RV32(rs5_lsu_pkg::RV32M), .MEM_WORDS(256)) dut0 (.*);

    always #(PERIOD / 2) clk = ~clk;

    // One request for one cycle.
    task automatic issue(input rs5_lsu_pkg::iType_e op, input logic [31:0] addr,
                         input logic [31:0] mul, input logic [31:0] sdata, input logic [4:0] rd);
        @(negedge clk);
        req_i.valid      = 1'b1;
        req_i.op         = op;
        req_i.result     = addr;
        req_i.mul_result = mul;
        req_i.store_data = sdata;
        req_i.rd         = rd;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req_i.valid = 1'b0;
        end
    endtask

    task automatic read_reg(input logic [4:0] rd, output logic [31:0] val);
        @(negedge clk);
        rs_addr_i = rd;                          // Held over the next edge for the checker.
        #1 val = rs_data_o;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic sweep();
        logic [31:0] val;
        for (int r = 0; r < 32; r++) begin
            read_reg(r, val);
            if (r == 0) expect_eq("rs_data_o x0", 32'h0, val);
        end
    endtask

    // BREADY stays high, so the response ends one cycle after BVALID.
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        @(negedge clk);
        while (!s_awready_o) @(negedge clk);
        expect_eq("s_wready_o", 32'h1, s_wready_o);  // Raised together with AWREADY.
        @(negedge clk);                          // Handshake edge has passed.
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        while (!s_bvalid_o) @(negedge clk);
        expect_eq("s_bresp_o", 32'h0, s_bresp_o);    // OKAY.
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        @(negedge clk);
        while (!s_arready_o) @(negedge clk);
        @(negedge clk);
        s_arvalid_i = 1'b0;
        while (!s_rvalid_o) @(negedge clk);
        expect_eq("s_rresp_o", 32'h0, s_rresp_o);    // OKAY.
        data = s_rdata_o;
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %0d %s finished, %0d errors so far", tests, name,
                 errors + dut0.chk0.fail_cnt);
    endtask

    initial begin
        logic [31:0] base;
        logic [31:0] val;
        logic [31:0] r0;
        logic [31:0] cnt;
        logic [4:0]  rd;
        req_i       = '0;
        rs_addr_i   = 5'd0;
        s_awaddr_i  = 32'h0;
        s_wdata_i   = 32'h0;
        s_araddr_i  = 32'h0;
        s_wstrb_i   = 4'hf;
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        s_arvalid_i = 1'b0;
        s_bready_i  = 1'b1;
        s_rready_i  = 1'b1;
        reset_i     = 1'b1;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        // ALU to even rd, MUL to odd rd; x0 is hit by both.
        for (int i = 0; i < 31; i += 2) begin
            issue(rs5_lsu_pkg::ALU, $random(seed), $random(seed), 32'h0, i);
            issue(rs5_lsu_pkg::MUL, $random(seed), $random(seed), 32'h0, i + 1);
        end
        issue(rs5_lsu_pkg::MUL, $random(seed), $random(seed), 32'h0, 5'd0);
        accepted += 33;                          // Writes to x0 still retire.
        idle(2);
        sweep();
        report("alu_mul");

        // Word, half and byte stores, then every load type at every lane.
        for (int w = 0; w < 4; w++) begin
            base = $random(seed) & 32'h0000_03fc;
            issue(rs5_lsu_pkg::SW, base, 32'h0, $random(seed), 5'd31);  // Store rd is ignored.
            issue(rs5_lsu_pkg::SH, base + 2 * ($random(seed) & 1), 32'h0, $random(seed), 5'd31);
            issue(rs5_lsu_pkg::SB, base + ($random(seed) & 3), 32'h0, $random(seed), 5'd31);
            rd = 5'd1;
            for (int lane = 0; lane < 4; lane++) begin
                issue(rs5_lsu_pkg::LB, base + lane, 32'h0, 32'h0, rd);
                issue(rs5_lsu_pkg::LBU, base + lane, 32'h0, 32'h0, rd + 5'd1);
                rd = rd + 5'd2;
            end
            for (int half = 0; half < 2; half++) begin
                issue(rs5_lsu_pkg::LH, base + 2 * half, 32'h0, 32'h0, rd);
                issue(rs5_lsu_pkg::LHU, base + 2 * half, 32'h0, 32'h0, rd + 5'd1);
                rd = rd + 5'd2;
            end
            issue(rs5_lsu_pkg::LW, base, 32'h0, 32'h0, rd);
            accepted += 16;
            idle(2);
            sweep();
        end
        report("store_load");

        // Load right behind a store to the same word, then a burst of writes.
        base = $random(seed) & 32'h0000_03fc;
        val  = $random(seed);
        issue(rs5_lsu_pkg::SW, base, 32'h0, val, 5'd0);
        issue(rs5_lsu_pkg::LW, base, 32'h0, 32'h0, 5'd20);
        for (int i = 21; i < 25; i++) issue(rs5_lsu_pkg::ALU, $random(seed), 32'h0, 32'h0, i);
        accepted += 6;
        idle(2);
        read_reg(5'd20, r0);
        expect_eq("rs_data_o x20", val, r0);
        sweep();
        report("back_to_back");

        // Four misaligned accesses; x20 and the word must keep their values.
        issue(rs5_lsu_pkg::LH, base + 1, 32'h0, 32'h0, 5'd20);
        issue(rs5_lsu_pkg::LW, base + 2, 32'h0, 32'h0, 5'd20);
        issue(rs5_lsu_pkg::SH, base + 3, 32'h0, ~val, 5'd0);
        issue(rs5_lsu_pkg::SW, base + 1, 32'h0, ~val, 5'd0);
        issue(rs5_lsu_pkg::LW, base, 32'h0, 32'h0, 5'd21);
        accepted += 1;                           // Only the aligned load.
        idle(2);
        read_reg(5'd20, r0);
        expect_eq("rs_data_o x20", val, r0);
        read_reg(5'd21, r0);
        expect_eq("rs_data_o x21", val, r0);
        axi_read(rs5_lsu_pkg::CSR_MISALIGN, r0);
        expect_eq("s_rdata_o MISALIGN", 32'd4, r0);
        axi_read(rs5_lsu_pkg::CSR_CTRL, r0);
        expect_eq("s_rdata_o CTRL", 32'h3, r0);  // Enabled, flag set.
        axi_write(rs5_lsu_pkg::CSR_CTRL, 32'h3);
        axi_read(rs5_lsu_pkg::CSR_CTRL, r0);
        expect_eq("s_rdata_o CTRL", 32'h1, r0);
        report("misalign");

        // Disabled requests are ignored, counting resumes after enable.
        axi_read(rs5_lsu_pkg::CSR_RETIRED, cnt);
        expect_eq("s_rdata_o RETIRED", accepted, cnt);
        axi_write(rs5_lsu_pkg::CSR_CTRL, 32'h0);
        for (int i = 0; i < 6; i++) issue(rs5_lsu_pkg::ALU, $random(seed), 32'h0, 32'h0, 5'd25);
        issue(rs5_lsu_pkg::SW, base, 32'h0, ~val, 5'd0);
        issue(rs5_lsu_pkg::LH, base + 1, 32'h0, 32'h0, 5'd25);
        idle(2);
        axi_read(rs5_lsu_pkg::CSR_RETIRED, cnt);
        expect_eq("s_rdata_o RETIRED", accepted, cnt);
        axi_read(rs5_lsu_pkg::CSR_MISALIGN, cnt);
        expect_eq("s_rdata_o MISALIGN", 32'd4, cnt);
        axi_write(rs5_lsu_pkg::CSR_CTRL, 32'h1);
        for (int i = 0; i < 4; i++) issue(rs5_lsu_pkg::ALU, $random(seed), 32'h0, 32'h0, 5'd25);
        issue(rs5_lsu_pkg::LW, base, 32'h0, 32'h0, 5'd26);
        accepted += 5;
        idle(2);
        axi_read(rs5_lsu_pkg::CSR_RETIRED, cnt);
        expect_eq("s_rdata_o RETIRED", accepted, cnt);
        read_reg(5'd26, cnt);
        expect_eq("rs_data_o x26", val, cnt);
        sweep();
        report("enable");

        errors = errors + dut0.chk0.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #((8 + TEST_CYCLES + MARGIN) * PERIOD);
        $display("Timeout, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule
